//--- verilog/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Machine word, bit 0 is the most significant
`define WORD_BITS 16

// r0 holds the flags, r1 to r7 are general registers
`define NUM_REGS 8

// Clock cycles a strobe may wait for rok_ before the alarm
`define BUS_TIMEOUT 32

`endif

//--- verilog/cpu_isa_pkg.sv
package cpu_isa_pkg;

	// Major opcodes, every other value halts the processor
	typedef enum logic [0:5] {
		LW   = 6'o20,
		TW   = 6'o21,
		RW   = 6'o24,
		AW   = 6'o40,
		SW   = 6'o42,
		OR_W = 6'o44,
		NR   = 6'o46,
		HLT  = 6'o73
	} opcode_t;

	// Instruction word, always followed by the argument N
	typedef struct packed {
		opcode_t    opcode;
		logic       d;
		logic [0:2] ra;
		logic [0:2] rb;
		logic [0:2] rc;
	} instr_t;

	typedef enum logic [0:1] {
		ADD,
		SUB,
		OR,
		AND
	} alu_op_t;

	// Lives in r0 bits 0 to 3
	typedef struct packed {
		logic z;
		logic m;
		logic v;
		logic c;
	} flags_t;

	typedef struct packed {
		logic    reg_we;
		logic    use_alu;
		alu_op_t alu_op;
		logic    flags_all;
		logic    flags_zm;
		logic    mem_read;
		logic    mem_write;
		logic    halt;
	} ctl_t;

endpackage

//--- verilog/cpu_bus_pkg.sv
`include "cpu_macros.svh"

package cpu_bus_pkg;

	// Request from the sequencer, true values and active high
	typedef struct packed {
		logic                  rd;
		logic                  wr;
		logic [0:`WORD_BITS-1] addr;
		logic [0:`WORD_BITS-1] data;
	} bus_req_t;

	// One-cycle reply, either ok or nomem
	typedef struct packed {
		logic                  ok;
		logic                  nomem;
		logic [0:`WORD_BITS-1] data;
	} bus_rsp_t;

	typedef enum logic [2:0] {
		IDLE,
		P0_FETCH,
		P1_ARG,
		P4_EXEC,
		HALTED,
		ALARM
	} seq_state_t;

endpackage

//--- verilog/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder
	import cpu_isa_pkg::*;
(
	input  instr_t instr,
	output ctl_t   ctl
);

	always_comb begin
		ctl = '0;
		ctl.alu_op = ADD;
		case (instr.opcode)
			LW: begin
				ctl.reg_we = 1'b1;
			end
			TW: begin
				ctl.reg_we = 1'b1;
				ctl.mem_read = 1'b1;
			end
			RW: begin
				ctl.mem_write = 1'b1;
			end
			AW, SW: begin
				ctl.reg_we = 1'b1;
				ctl.use_alu = 1'b1;
				ctl.alu_op = (instr.opcode == SW) ? SUB : ADD;
				ctl.flags_all = 1'b1;
			end
			OR_W, NR: begin
				ctl.reg_we = 1'b1;
				ctl.use_alu = 1'b1;
				ctl.alu_op = (instr.opcode == NR) ? AND : OR;
				ctl.flags_zm = 1'b1;
			end
			// HLT and anything unknown
			default: begin
				ctl.halt = 1'b1;
			end
		endcase
	end

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module reg_file
	import cpu_isa_pkg::*;
(
	input  logic                  __clk,
	input  logic                  rst_n,
	input  logic [0:2]            rsel,
	input  logic [0:`WORD_BITS-1] wdata,
	input  logic                  we,
	input  flags_t                flags_in,
	input  logic                  flags_we_all,
	input  logic                  flags_we_zm,
	output logic [0:`WORD_BITS-1] rdata,
	output flags_t                flags
);

	localparam int FLAG_BITS = $bits(flags_t);

	logic [0:`WORD_BITS-1] regs [0:`NUM_REGS-1];
	logic                  r0_write;

	assign r0_write = we && (rsel == 3'd0);

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `NUM_REGS; i++)
				regs[i] <= '0;
		end else begin
			if (r0_write)
				regs[0] <= {wdata[0:FLAG_BITS-1], {(`WORD_BITS-FLAG_BITS){1'b0}}};
			else if (we)
				regs[rsel] <= wdata;
			// Writing r0 itself wins over the flag update
			if (!r0_write) begin
				if (flags_we_all)
					regs[0][0:FLAG_BITS-1] <= flags_in;
				else if (flags_we_zm)
					regs[0][0:1] <= {flags_in.z, flags_in.m};
			end
		end
	end

	assign rdata = regs[rsel];
	assign flags = flags_t'(regs[0][0:FLAG_BITS-1]);

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module alu
	import cpu_isa_pkg::*;
(
	input  logic [0:`WORD_BITS-1] a,
	input  logic [0:`WORD_BITS-1] b,
	input  alu_op_t               op,
	input  flags_t                flags_old,
	output logic [0:`WORD_BITS-1] result,
	output flags_t                flags_new
);

	logic                  arith;
	logic                  cin;
	logic [0:`WORD_BITS-1] b_eff;
	// Bit 0 is the carry out of the word's bit 0
	logic [0:`WORD_BITS]   sum;

	assign arith = (op == ADD) || (op == SUB);
	assign cin = (op == SUB);

	// Subtraction as a + ~b + 1
	assign b_eff = cin ? ~b : b;
	assign sum = a + b_eff + cin;

	always_comb begin
		flags_new = flags_old;
		case (op)
			ADD, SUB: result = sum[1:`WORD_BITS];
			OR:       result = a | b;
			default:  result = a & b;
		endcase
		flags_new.z = (result == '0);
		flags_new.m = result[0];
		// v and c pass through for the logic ops
		if (arith) begin
			flags_new.v = (a[0] == b_eff[0]) && (result[0] != a[0]);
			flags_new.c = sum[0];
		end
	end

endmodule

//--- verilog/cycle_sequencer.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cycle_sequencer
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;
(
	input  logic                  __clk,
	input  logic                  rst_n,
	input  logic                  start_,
	input  ctl_t                  ctl,
	output instr_t                instr,
	output bus_req_t              bus_req,
	input  bus_rsp_t              bus_rsp,
	output logic [0:2]            rsel,
	output logic [0:`WORD_BITS-1] wdata,
	output logic                  we,
	output logic                  flags_we_all,
	output logic                  flags_we_zm,
	input  logic [0:`WORD_BITS-1] rdata,
	input  logic [0:`WORD_BITS-1] alu_result,
	output alu_op_t               alu_op,
	output logic [0:`WORD_BITS-1] arg,
	output logic                  run,
	output logic                  hlt_n_
);

	seq_state_t            state;
	logic [0:`WORD_BITS-1] ic;
	instr_t                ir;
	logic [0:`WORD_BITS-1] arg_q;
	logic                  bus_busy;
	logic                  exec;

	assign bus_busy = bus_req.rd | bus_req.wr;
	assign exec = (state == P4_EXEC);

	// ------------------------------------------------------------------------
	// Instruction cycle
	// ------------------------------------------------------------------------

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			state <= IDLE;
			ic <= '0;
			bus_req <= '0;
		end else if (bus_rsp.nomem) begin
			// No memory at this address
			bus_req <= '0;
			state <= ALARM;
		end else begin
			case (state)
				IDLE: begin
					if (!start_)
						state <= P0_FETCH;
				end
				P0_FETCH: begin
					if (bus_rsp.ok) begin
						bus_req <= '0;
						ir <= instr_t'(bus_rsp.data);
						state <= P1_ARG;
					end else if (!bus_busy) begin
						bus_req <= '{rd: 1'b1, wr: 1'b0, addr: ic, data: '0};
					end
				end
				P1_ARG: begin
					if (bus_rsp.ok) begin
						bus_req <= '0;
						arg_q <= bus_rsp.data;
						state <= P4_EXEC;
					end else if (!bus_busy) begin
						bus_req <= '{rd: 1'b1, wr: 1'b0, addr: ic + 1'b1, data: '0};
					end
				end
				P4_EXEC: begin
					if (ctl.halt) begin
						ic <= ic + 2'd2;
						state <= HALTED;
					end else if (ctl.mem_read || ctl.mem_write) begin
						if (bus_rsp.ok) begin
							bus_req <= '0;
							ic <= ic + 2'd2;
							state <= P0_FETCH;
						end else if (!bus_busy) begin
							bus_req <= '{rd: ctl.mem_read, wr: ctl.mem_write,
								addr: arg_q, data: rdata};
						end
					end else begin
						// Register operation done in one cycle
						ic <= ic + 2'd2;
						state <= P0_FETCH;
					end
				end
				default: begin
					// HALTED and ALARM wait for reset
					bus_req <= '0;
				end
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// Register file and ALU control
	// ------------------------------------------------------------------------

	assign instr = ir;
	assign arg = arg_q;
	assign rsel = ir.ra;
	assign alu_op = ctl.alu_op;

	always_comb begin
		if (ctl.use_alu)
			wdata = alu_result;
		else if (ctl.mem_read)
			wdata = bus_rsp.data;
		else
			wdata = arg_q;
	end

	// TW writes in the cycle the memory data arrives
	assign we = exec && ctl.reg_we && (!ctl.mem_read || bus_rsp.ok);
	assign flags_we_all = exec && ctl.flags_all;
	assign flags_we_zm = exec && ctl.flags_zm;

	assign run = (state == P0_FETCH) || (state == P1_ARG) || exec;
	assign hlt_n_ = (state != HALTED);

endmodule

//--- verilog/bus_interface.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module bus_interface
	import cpu_bus_pkg::*;
(
	input  logic                  __clk,
	input  logic                  rst_n,
	input  bus_req_t              req,
	output bus_rsp_t              rsp,
	output logic                  dr_,
	output logic                  dw_,
	output logic [0:`WORD_BITS-1] dad_,
	output logic [0:`WORD_BITS-1] ddt_,
	input  logic                  rok_,
	input  logic [0:`WORD_BITS-1] rdt_,
	output logic                  awaria_
);

	localparam int CNT_BITS = $clog2(`BUS_TIMEOUT);

	logic                strobe;
	logic                waiting;
	logic [CNT_BITS-1:0] wait_cnt;
	logic                alarm;

	// Open-collector lines idle high
	assign strobe = req.rd | req.wr;
	assign dr_ = ~req.rd;
	assign dw_ = ~req.wr;
	assign dad_ = strobe ? ~req.addr : '1;
	assign ddt_ = req.wr ? ~req.data : '1;

	// Nothing more is taken once the reply is out
	assign waiting = strobe && !rsp.ok && !rsp.nomem;

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			rsp.ok <= 1'b0;
			rsp.nomem <= 1'b0;
			wait_cnt <= '0;
			alarm <= 1'b0;
		end else begin
			rsp.ok <= 1'b0;
			rsp.nomem <= 1'b0;
			if (!waiting) begin
				wait_cnt <= '0;
			end else if (!rok_) begin
				rsp.ok <= 1'b1;
				rsp.data <= ~rdt_;
				wait_cnt <= '0;
			end else if (wait_cnt == CNT_BITS'(`BUS_TIMEOUT - 1)) begin
				rsp.nomem <= 1'b1;
				alarm <= 1'b1;
				wait_cnt <= '0;
			end else begin
				wait_cnt <= wait_cnt + 1'b1;
			end
		end
	end

	assign awaria_ = ~alarm;

endmodule

//--- verilog/cpu.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;
(
	input  logic                  __clk,
	input  logic                  rst_n,
	input  logic                  start_,
	input  logic                  rok_,
	input  logic [0:`WORD_BITS-1] rdt_,
	output logic                  dr_,
	output logic                  dw_,
	output logic [0:`WORD_BITS-1] dad_,
	output logic [0:`WORD_BITS-1] ddt_,
	output logic                  run,
	output logic                  hlt_n_,
	output logic                  awaria_
);

	// ------------------------------------------------------------------------
	// Decode and sequencing
	// ------------------------------------------------------------------------

	instr_t                instr;
	ctl_t                  ctl;
	bus_req_t              bus_req;
	bus_rsp_t              bus_rsp;
	logic [0:2]            rsel;
	logic [0:`WORD_BITS-1] wdata;
	logic                  we;
	logic                  flags_we_all;
	logic                  flags_we_zm;
	logic [0:`WORD_BITS-1] rdata;
	logic [0:`WORD_BITS-1] alu_result;
	alu_op_t               alu_op;
	logic [0:`WORD_BITS-1] arg;
	flags_t                flags;
	flags_t                flags_new;

	instr_decoder i_decoder (
		.instr(instr),
		.ctl(ctl)
	);

	cycle_sequencer i_seq (
		.__clk(__clk),
		.rst_n(rst_n),
		.start_(start_),
		.ctl(ctl),
		.instr(instr),
		.bus_req(bus_req),
		.bus_rsp(bus_rsp),
		.rsel(rsel),
		.wdata(wdata),
		.we(we),
		.flags_we_all(flags_we_all),
		.flags_we_zm(flags_we_zm),
		.rdata(rdata),
		.alu_result(alu_result),
		.alu_op(alu_op),
		.arg(arg),
		.run(run),
		.hlt_n_(hlt_n_)
	);

	// ------------------------------------------------------------------------
	// Registers and ALU
	// ------------------------------------------------------------------------

	reg_file i_regs (
		.__clk(__clk),
		.rst_n(rst_n),
		.rsel(rsel),
		.wdata(wdata),
		.we(we),
		.flags_in(flags_new),
		.flags_we_all(flags_we_all),
		.flags_we_zm(flags_we_zm),
		.rdata(rdata),
		.flags(flags)
	);

	// rA against N
	alu i_alu (
		.a(rdata),
		.b(arg),
		.op(alu_op),
		.flags_old(flags),
		.result(alu_result),
		.flags_new(flags_new)
	);

	// ------------------------------------------------------------------------
	// System bus
	// ------------------------------------------------------------------------

	bus_interface i_bus (
		.__clk(__clk),
		.rst_n(rst_n),
		.req(bus_req),
		.rsp(bus_rsp),
		.dr_(dr_),
		.dw_(dw_),
		.dad_(dad_),
		.ddt_(ddt_),
		.rok_(rok_),
		.rdt_(rdt_),
		.awaria_(awaria_)
	);

endmodule

//--- tests/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_tb
	import cpu_isa_pkg::*;
();

	localparam int MEM_WORDS = 256;
	localparam int DATA_BASE = 128;
	localparam int STORE_BASE = 192;
	localparam int GROUPS = 13;
	localparam int RUN_TIMEOUT = 5000;
	localparam logic [0:`WORD_BITS-1] NOMEM_ADDR = 16'h0400;

	logic                  __clk = 1'b0;
	logic                  rst_n;
	logic                  start_;
	logic                  rok_ = 1'b1;
	logic [0:`WORD_BITS-1] rdt_ = '1;
	logic                  dr_;
	logic                  dw_;
	logic [0:`WORD_BITS-1] dad_;
	logic [0:`WORD_BITS-1] ddt_;
	logic                  run;
	logic                  hlt_n_;
	logic                  awaria_;

	integer seed;
	int     errors;

	logic [0:`WORD_BITS-1] mem [0:MEM_WORDS-1];
	logic [0:`WORD_BITS-1] image [0:MEM_WORDS-1];
	logic [0:`WORD_BITS-1] bus_addr;
	int                    mem_delay;
	logic                  mem_busy;
	logic                  mem_done;

	// Expected bus writes in program order
	logic [0:`WORD_BITS-1] exp_addr [0:63];
	logic [0:`WORD_BITS-1] exp_data [0:63];
	logic                  exp_is_r0 [0:63];
	int                    exp_count;
	int                    write_idx;
	logic                  write_seen;
	logic [0:`WORD_BITS-1] seen_addr;
	logic [0:`WORD_BITS-1] seen_data;

	opcode_t ops [0:5] = '{LW, TW, AW, SW, OR_W, NR};

	cpu i_cpu (
		.__clk(__clk),
		.rst_n(rst_n),
		.start_(start_),
		.rok_(rok_),
		.rdt_(rdt_),
		.dr_(dr_),
		.dw_(dw_),
		.dad_(dad_),
		.ddt_(ddt_),
		.run(run),
		.hlt_n_(hlt_n_),
		.awaria_(awaria_)
	);

	always #5 __clk = ~__clk;

	// ------------------------------------------------------------------------
	// Failure handling and compare tasks
	// ------------------------------------------------------------------------

	task automatic stop_run(input string reason);
		errors++;
		$display("%s", reason);
		$display("=== FAIL ===");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_word(input string what, input logic [0:`WORD_BITS-1] got,
			input logic [0:`WORD_BITS-1] exp);
		if (got !== exp)
			stop_run($sformatf("** Error at %0t: %s is %h, expected %h",
				$realtime, what, got, exp));
	endtask

	task automatic check_flags(input string what, input flags_t got, input flags_t exp);
		if (got !== exp)
			stop_run($sformatf("** Error at %0t: %s zmvc is %b, expected %b",
				$realtime, what, got, exp));
	endtask

	task automatic check_status(input logic exp_run, input logic exp_hlt_n_,
			input logic exp_awaria_);
		if ({run, hlt_n_, awaria_} !== {exp_run, exp_hlt_n_, exp_awaria_})
			stop_run($sformatf("** Error at %0t: run hlt_n_ awaria_ is %b, expected %b",
				$realtime, {run, hlt_n_, awaria_}, {exp_run, exp_hlt_n_, exp_awaria_}));
	endtask

	// ------------------------------------------------------------------------
	// Program generation and reference interpreter
	// ------------------------------------------------------------------------

	task automatic put_instr(inout int pc, input opcode_t op, input int ra,
			input logic [0:`WORD_BITS-1] n);
		instr_t ins;
		ins = '0;
		ins.opcode = op;
		ins.ra = ra[2:0];
		mem[pc] = ins;
		mem[pc + 1] = n;
		pc += 2;
	endtask

	task automatic build_program();
		int                    pc;
		int                    ra;
		opcode_t               op;
		logic [0:`WORD_BITS-1] n;
		for (int a = 0; a < MEM_WORDS; a++)
			mem[a] = 16'(a * 16'h3d1) ^ 16'ha5c3;
		for (int a = DATA_BASE; a < MEM_WORDS; a++)
			mem[a] = $random(seed);
		pc = 0;
		// Each group stores its register and then the flags
		for (int g = 0; g < GROUPS; g++) begin
			op = (g < 6) ? ops[g] : ops[{$random(seed)} % 6];
			ra = {$random(seed)} % 8;
			if (op == TW)
				n = 16'(DATA_BASE + {$random(seed)} % (MEM_WORDS - DATA_BASE));
			else
				n = $random(seed);
			put_instr(pc, op, ra, n);
			put_instr(pc, RW, ra, 16'(STORE_BASE + 2 * g));
			put_instr(pc, RW, 0, 16'(STORE_BASE + 2 * g + 1));
		end
		put_instr(pc, HLT, 0, '0);
		for (int a = 0; a < MEM_WORDS; a++)
			image[a] = mem[a];
	endtask

	// r0 keeps only the four flag bits
	function automatic logic [0:`WORD_BITS-1] reg_value(input logic [0:2] sel,
			input logic [0:`WORD_BITS-1] v);
		if (sel == 3'd0)
			return v & 16'hf000;
		return v;
	endfunction

	function automatic int interpret_program();
		logic [0:`WORD_BITS-1] r [0:`NUM_REGS-1];
		logic [0:`WORD_BITS-1] ref_mem [0:MEM_WORDS-1];
		logic [0:`WORD_BITS-1] n;
		logic [0:`WORD_BITS-1] res;
		instr_t                ins;
		flags_t                f;
		int unsigned           total;
		int                    sa;
		int                    sn;
		int                    full;
		int                    pc;
		int                    nw;
		logic                  done;
		logic                  update;
		for (int i = 0; i < `NUM_REGS; i++)
			r[i] = '0;
		for (int a = 0; a < MEM_WORDS; a++)
			ref_mem[a] = image[a];
		pc = 0;
		nw = 0;
		done = 1'b0;
		while (!done && pc < MEM_WORDS - 1) begin
			ins = instr_t'(ref_mem[pc]);
			n = ref_mem[pc + 1];
			pc += 2;
			f = flags_t'(r[0][0:3]);
			update = 1'b0;
			case (ins.opcode)
				LW: r[ins.ra] = reg_value(ins.ra, n);
				TW: r[ins.ra] = reg_value(ins.ra, ref_mem[n[8:15]]);
				RW: begin
					ref_mem[n[8:15]] = r[ins.ra];
					exp_addr[nw] = n;
					exp_data[nw] = r[ins.ra];
					exp_is_r0[nw] = (ins.ra == 3'd0);
					nw++;
				end
				AW, SW: begin
					total = r[ins.ra];
					if (ins.opcode == AW)
						total = total + n;
					else
						total = total + (16'hffff - n) + 1;
					sa = $signed(r[ins.ra]);
					sn = $signed(n);
					full = (ins.opcode == AW) ? sa + sn : sa - sn;
					res = total[15:0];
					f.z = (res == '0);
					f.m = res[0];
					f.v = (full > 32767) || (full < -32768);
					f.c = (total > 65535);
					update = 1'b1;
				end
				OR_W, NR: begin
					res = (ins.opcode == OR_W) ? (r[ins.ra] | n) : (r[ins.ra] & n);
					f.z = (res == '0);
					f.m = res[0];
					update = 1'b1;
				end
				default: done = 1'b1;
			endcase
			if (update) begin
				if (ins.ra == 3'd0) begin
					r[0] = reg_value(3'd0, res);
				end else begin
					r[ins.ra] = res;
					r[0][0:3] = f;
				end
			end
		end
		return nw;
	endfunction

	// ------------------------------------------------------------------------
	// Memory model and write monitor
	// ------------------------------------------------------------------------

	always @(negedge __clk) begin
		rok_ <= 1'b1;
		rdt_ <= '1;
		if (!rst_n || (dr_ && dw_)) begin
			mem_busy = 1'b0;
			mem_done = 1'b0;
		end else if (!mem_done) begin
			bus_addr = ~dad_;
			if (!mem_busy) begin
				mem_busy = 1'b1;
				mem_delay = {$random(seed)} % 4;
			end
			// Nothing answers above the last word
			if (bus_addr < MEM_WORDS) begin
				if (mem_delay == 0) begin
					rok_ <= 1'b0;
					if (!dr_)
						rdt_ <= ~mem[bus_addr[8:15]];
					else
						mem[bus_addr[8:15]] = ~ddt_;
					mem_done = 1'b1;
				end else begin
					mem_delay--;
				end
			end
		end
	end

	always @(negedge __clk) begin
		if (!rst_n) begin
			write_seen = 1'b0;
			write_idx = 0;
		end else if (dw_) begin
			write_seen = 1'b0;
		end else if (!write_seen) begin
			write_seen = 1'b1;
			seen_addr = ~dad_;
			seen_data = ~ddt_;
			if (write_idx >= exp_count) begin
				stop_run("Unexpected write strobe on the bus");
			end else begin
				if (exp_is_r0[write_idx])
					check_flags("flags stored from r0", flags_t'(seen_data[0:3]),
						flags_t'(exp_data[write_idx][0:3]));
				check_word("write address", seen_addr, exp_addr[write_idx]);
				check_word("write data", seen_data, exp_data[write_idx]);
				write_idx++;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------

	task automatic apply_reset();
		@(negedge __clk);
		rst_n = 1'b0;
		repeat (16) @(negedge __clk);
		rst_n = 1'b1;
		@(negedge __clk);
		check_status(1'b0, 1'b1, 1'b1);
		if (!dr_ || !dw_)
			stop_run("Bus strobe active after reset");
	endtask

	task automatic pulse_start();
		start_ = 1'b0;
		@(negedge __clk);
		start_ = 1'b1;
	endtask

	initial begin
		int cycles;
		$timeformat(-9, 0, " ns", 0);
		seed = 10;
		errors = 0;
		rst_n = 1'b0;
		start_ = 1'b1;
		exp_count = 0;

		// Random program against the reference
		build_program();
		exp_count = interpret_program();
		apply_reset();
		pulse_start();
		check_status(1'b1, 1'b1, 1'b1);
		cycles = 0;
		while (hlt_n_ && cycles < RUN_TIMEOUT) begin
			@(negedge __clk);
			cycles++;
		end
		if (hlt_n_)
			stop_run("Timeout: the processor never halted");
		check_status(1'b0, 1'b0, 1'b1);
		if (write_idx != exp_count)
			stop_run($sformatf("Only %0d of %0d expected writes were seen",
				write_idx, exp_count));
		for (int i = 0; i < 50; i++) begin
			@(negedge __clk);
			if (!dr_ || !dw_)
				stop_run("Bus strobe after the halt");
		end

		// TW from an address with no memory behind it
		mem[0] = instr_t'{opcode: TW, d: 1'b0, ra: 3'd1, rb: 3'd0, rc: 3'd0};
		mem[1] = NOMEM_ADDR;
		exp_count = 0;
		apply_reset();
		pulse_start();
		check_status(1'b1, 1'b1, 1'b1);
		cycles = 0;
		while (!(!dr_ && (~dad_) == NOMEM_ADDR) && cycles < 100) begin
			@(negedge __clk);
			cycles++;
		end
		if (dr_ || (~dad_) != NOMEM_ADDR)
			stop_run("Timeout: no read strobe at the missing address");
		cycles = 0;
		while (awaria_ && cycles < `BUS_TIMEOUT + 3) begin
			@(negedge __clk);
			cycles++;
		end
		if (awaria_)
			stop_run("Timeout: awaria_ did not go low for missing memory");
		cycles = 0;
		while ((!dr_ || !dw_) && cycles < 3) begin
			@(negedge __clk);
			cycles++;
		end
		if (!dr_ || !dw_)
			stop_run("Bus strobes not released after the alarm");
		check_status(1'b0, 1'b1, 1'b0);
		for (int i = 0; i < 10; i++) begin
			@(negedge __clk);
			if (!dr_ || !dw_)
				stop_run("Bus strobe after the alarm");
		end

		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- compile.f
+incdir+verilog
verilog/cpu_isa_pkg.sv
verilog/cpu_bus_pkg.sv
verilog/instr_decoder.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/cycle_sequencer.sv
verilog/bus_interface.sv
verilog/cpu.sv
tests/cpu_tb.sv
